/* hdl/chiplet_types_pkg.sv */
`default_nettype none

package chiplet_types_pkg;

    // link sizing
    localparam int NUM_VCS   = 4;
    localparam int VC_DEPTH  = 8;
    localparam int VC_BITS   = 2;
    localparam int CNT_BITS  = 4;
    localparam int DROP_BITS = 8;

    typedef logic [VC_BITS-1:0] vc_t;

    // par is even parity over vc, id and payload
    typedef struct packed {
        vc_t         vc;
        logic [3:0]  id;
        logic [31:0] payload;
        logic        par;
    } flit_t;

    // one-hot write into the channel FIFOs
    typedef struct packed {
        logic [NUM_VCS-1:0] wen;
        flit_t              wdata;
    } buf_req_t;

    typedef struct packed {
        logic [NUM_VCS-1:0][CNT_BITS-1:0] count;
        logic [NUM_VCS-1:0]               full;
        logic [NUM_VCS-1:0]               empty;
        // single-cycle pulses
        logic [NUM_VCS-1:0]               overrun;
    } buf_state_t;

    typedef enum logic [1:0] {
        CMD_NOP       = 2'd0,
        CMD_CLEAR_VC  = 2'd1,
        CMD_CLEAR_ALL = 2'd2,
        CMD_ACK_ERR   = 2'd3
    } cmd_op_e;

    typedef struct packed {
        logic [NUM_VCS-1:0][CNT_BITS-1:0] count;
        logic [NUM_VCS-1:0]               overrun_sticky;
        logic [DROP_BITS-1:0]             drop_count;
    } rx_status_t;

endpackage

`default_nettype wire

/* hdl/flit_buffers.sv */
`timescale 1ns/10ps
`default_nettype none

module flit_buffers #(
    parameter int NUM_BUFFERS = chiplet_types_pkg::NUM_VCS,
    parameter int DEPTH       = chiplet_types_pkg::VC_DEPTH
) (
    input  logic                                         CLK,
    input  logic                                         nRST,
    input  chiplet_types_pkg::buf_req_t                  buf_req,
    input  logic [NUM_BUFFERS-1:0]                       ren,
    input  logic [NUM_BUFFERS-1:0]                       clear,
    output chiplet_types_pkg::flit_t [NUM_BUFFERS-1:0]   rdata,
    output chiplet_types_pkg::buf_state_t                state
);

    import chiplet_types_pkg::*;

    localparam int ADDR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W     = $clog2(DEPTH + 1);

    // elaboration checks
    if (DEPTH < 1 || (DEPTH & (DEPTH - 1)) != 0) begin : g_depth_check
        $error("%m: DEPTH must be a power of two");
    end
    if (CNT_W > CNT_BITS) begin : g_count_check
        $error("%m: DEPTH does not fit the status count width");
    end
    if (NUM_BUFFERS != NUM_VCS) begin : g_num_check
        $error("%m: NUM_BUFFERS must match the number of virtual channels");
    end

    logic [NUM_BUFFERS-1:0][ADDR_BITS-1:0] wptr;
    logic [NUM_BUFFERS-1:0][ADDR_BITS-1:0] rptr;
    logic [NUM_BUFFERS-1:0][CNT_W-1:0]     count;
    logic [NUM_BUFFERS-1:0]                overrun_q;
    logic [NUM_BUFFERS-1:0]                overrun_next;
    logic [NUM_BUFFERS-1:0]                full;
    logic [NUM_BUFFERS-1:0]                empty;
    logic [NUM_BUFFERS-1:0]                do_wr;
    logic [NUM_BUFFERS-1:0]                do_rd;

    // shared storage with one row per buffer
    flit_t mem [NUM_BUFFERS][DEPTH];

    always_comb begin
        for (int i = 0; i < NUM_BUFFERS; i++) begin
            full[i]  = (count[i] == DEPTH);
            empty[i] = (count[i] == '0);
            // arbiter only pops non-empty buffers
            do_rd[i] = ren[i] && !clear[i];
            // a full buffer still takes a write if it is read in the same cycle
            do_wr[i] = buf_req.wen[i] && !clear[i] && (!full[i] || ren[i]);
            overrun_next[i] = buf_req.wen[i] && !clear[i] && full[i] && !ren[i];
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wptr      <= '0;
            rptr      <= '0;
            count     <= '0;
            overrun_q <= '0;
        end else begin
            overrun_q <= overrun_next;
            for (int i = 0; i < NUM_BUFFERS; i++) begin
                if (clear[i]) begin
                    wptr[i]  <= '0;
                    rptr[i]  <= '0;
                    count[i] <= '0;
                end else begin
                    // pointers wrap at DEPTH
                    if (do_wr[i]) begin
                        wptr[i] <= (int'(wptr[i]) == DEPTH - 1) ? '0 : wptr[i] + 1'b1;
                    end
                    if (do_rd[i]) begin
                        rptr[i] <= (int'(rptr[i]) == DEPTH - 1) ? '0 : rptr[i] + 1'b1;
                    end
                    count[i] <= count[i] + CNT_W'(do_wr[i]) - CNT_W'(do_rd[i]);
                end
            end
        end
    end

    // flit storage
    always_ff @(posedge CLK) begin
        for (int i = 0; i < NUM_BUFFERS; i++) begin
            if (do_wr[i]) begin
                mem[i][wptr[i]] <= buf_req.wdata;
            end
        end
    end

    always_comb begin
        state.full    = full;
        state.empty   = empty;
        state.overrun = overrun_q;
        for (int i = 0; i < NUM_BUFFERS; i++) begin
            state.count[i] = CNT_BITS'(count[i]);
            // head flit is valid whenever the buffer is not empty
            rdata[i] = mem[i][rptr[i]];
        end
    end

endmodule

`default_nettype wire

/* hdl/flit_ingress.sv */
`timescale 1ns/10ps
`default_nettype none

module flit_ingress (
    input  logic                                        CLK,
    input  logic                                        nRST,
    input  logic                                        in_valid,
    input  chiplet_types_pkg::flit_t                    in_flit,
    output chiplet_types_pkg::buf_req_t                 buf_req,
    output logic [chiplet_types_pkg::DROP_BITS-1:0]     drop_count
);

    import chiplet_types_pkg::*;

    logic                 valid_q;
    flit_t                flit_q;
    logic                 par_calc;
    logic                 par_ok;
    logic [NUM_VCS-1:0]   wen_next;
    logic [NUM_VCS-1:0]   wen_q;
    flit_t                wdata_q;
    logic [DROP_BITS-1:0] drop_q;

    // input capture stage
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (in_valid) begin
            flit_q <= in_flit;
        end
    end

    // parity recomputed over vc, id and payload
    always_comb begin
        par_calc = ^{flit_q.vc, flit_q.id, flit_q.payload};
        par_ok   = (par_calc == flit_q.par);
        wen_next = '0;
        if (valid_q && par_ok) begin
            wen_next[flit_q.vc] = 1'b1;
        end
    end

    // request stage
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wen_q  <= '0;
            drop_q <= '0;
        end else begin
            wen_q <= wen_next;
            // bad flits are counted, saturating
            if (valid_q && !par_ok && drop_q != '1) begin
                drop_q <= drop_q + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (valid_q) begin
            wdata_q <= flit_q;
        end
    end

    always_comb begin
        buf_req.wen   = wen_q;
        buf_req.wdata = wdata_q;
    end

    assign drop_count = drop_q;

endmodule

`default_nettype wire

/* hdl/vc_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module vc_arbiter (
    input  logic                                                    CLK,
    input  logic                                                    nRST,
    input  chiplet_types_pkg::buf_state_t                           state,
    input  chiplet_types_pkg::flit_t [chiplet_types_pkg::NUM_VCS-1:0] rdata,
    input  logic                                                    out_stall,
    output logic [chiplet_types_pkg::NUM_VCS-1:0]                   ren,
    output logic                                                    out_valid,
    output chiplet_types_pkg::flit_t                                out_flit
);

    import chiplet_types_pkg::*;

    vc_t   last_q;
    vc_t   grant_idx;
    logic  grant_valid;
    logic  pop;
    logic  out_valid_q;
    flit_t out_flit_q;

    // first non-empty channel after the last grant, circular order
    always_comb begin
        int idx;
        grant_valid = 1'b0;
        grant_idx   = last_q;
        for (int k = 1; k <= NUM_VCS; k++) begin
            idx = (int'(last_q) + k) % NUM_VCS;
            if (!grant_valid && !state.empty[idx]) begin
                grant_valid = 1'b1;
                grant_idx   = vc_t'(idx);
            end
        end
    end

    // no pop while the output is held
    always_comb begin
        pop = grant_valid && !out_stall;
        ren = '0;
        if (pop) begin
            ren[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            last_q      <= '0;
            out_valid_q <= 1'b0;
        end else begin
            out_valid_q <= pop;
            if (pop) begin
                last_q <= grant_idx;
            end
        end
    end

    // captured head flit
    always_ff @(posedge CLK) begin
        if (pop) begin
            out_flit_q <= rdata[grant_idx];
        end
    end

    assign out_valid = out_valid_q;
    assign out_flit  = out_flit_q;

endmodule

`default_nettype wire

/* hdl/buffer_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module buffer_ctrl (
    input  logic                                        CLK,
    input  logic                                        nRST,
    input  logic                                        cmd_valid,
    input  chiplet_types_pkg::cmd_op_e                  cmd_op,
    input  chiplet_types_pkg::vc_t                      cmd_vc,
    input  chiplet_types_pkg::buf_state_t               state,
    input  logic [chiplet_types_pkg::DROP_BITS-1:0]     drop_count,
    output logic [chiplet_types_pkg::NUM_VCS-1:0]       clear,
    output chiplet_types_pkg::rx_status_t               status
);

    import chiplet_types_pkg::*;

    logic [NUM_VCS-1:0] clear_next;
    logic [NUM_VCS-1:0] clear_q;
    logic               ack_next;
    logic               ack_q;
    logic [NUM_VCS-1:0] sticky_q;

    // command decode
    always_comb begin
        clear_next = '0;
        ack_next   = 1'b0;
        if (cmd_valid) begin
            case (cmd_op)
                CMD_CLEAR_VC:  clear_next[cmd_vc] = 1'b1;
                CMD_CLEAR_ALL: clear_next = '1;
                CMD_ACK_ERR:   ack_next = 1'b1;
                default:       clear_next = '0;
            endcase
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            clear_q  <= '0;
            ack_q    <= 1'b0;
            sticky_q <= '0;
        end else begin
            clear_q <= clear_next;
            ack_q   <= ack_next;
            // a pulse arriving with the ack keeps its bit set
            if (ack_q) begin
                sticky_q <= state.overrun;
            end else begin
                sticky_q <= sticky_q | state.overrun;
            end
        end
    end

    assign clear = clear_q;

    always_comb begin
        status.count          = state.count;
        status.overrun_sticky = sticky_q;
        status.drop_count     = drop_count;
    end

endmodule

`default_nettype wire

/* hdl/chiplet_rx_top.sv */
`timescale 1ns/10ps
`default_nettype none

module chiplet_rx_top (
    input  logic                           CLK,
    input  logic                           nRST,
    input  logic                           in_valid,
    input  chiplet_types_pkg::flit_t       in_flit,
    input  logic                           out_stall,
    input  logic                           cmd_valid,
    input  chiplet_types_pkg::cmd_op_e     cmd_op,
    input  chiplet_types_pkg::vc_t         cmd_vc,
    output logic                           out_valid,
    output chiplet_types_pkg::flit_t       out_flit,
    output chiplet_types_pkg::rx_status_t  status
);

    import chiplet_types_pkg::*;

    buf_req_t                  buf_req;
    buf_state_t                buf_state;
    flit_t [NUM_VCS-1:0]       rdata;
    logic  [NUM_VCS-1:0]       ren;
    logic  [NUM_VCS-1:0]       clear;
    logic  [DROP_BITS-1:0]     drop_count;

    flit_ingress u_ingress (
        .CLK        (CLK),
        .nRST       (nRST),
        .in_valid   (in_valid),
        .in_flit    (in_flit),
        .buf_req    (buf_req),
        .drop_count (drop_count)
    );

    flit_buffers #(
        .NUM_BUFFERS (NUM_VCS),
        .DEPTH       (VC_DEPTH)
    ) u_buffers (
        .CLK     (CLK),
        .nRST    (nRST),
        .buf_req (buf_req),
        .ren     (ren),
        .clear   (clear),
        .rdata   (rdata),
        .state   (buf_state)
    );

    vc_arbiter u_arbiter (
        .CLK       (CLK),
        .nRST      (nRST),
        .state     (buf_state),
        .rdata     (rdata),
        .out_stall (out_stall),
        .ren       (ren),
        .out_valid (out_valid),
        .out_flit  (out_flit)
    );

    buffer_ctrl u_ctrl (
        .CLK        (CLK),
        .nRST       (nRST),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_vc     (cmd_vc),
        .state      (buf_state),
        .drop_count (drop_count),
        .clear      (clear),
        .status     (status)
    );

endmodule

`default_nettype wire

/* bench/chiplet_rx_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module chiplet_rx_tb;

    import chiplet_types_pkg::*;

    typedef enum logic [2:0] {
        K_SEND, K_CMD, K_STALL_ON, K_STALL_OFF, K_WAIT, K_CHECK
    } row_kind_e;

    // one table row, fields a row does not use stay zero
    typedef struct packed {
        row_kind_e                        kind;
        vc_t                              vc;
        logic [3:0]                       id;
        logic                             bad;
        cmd_op_e                          op;
        logic [7:0]                       n;
        logic [NUM_VCS-1:0][CNT_BITS-1:0] cnt;
        logic [NUM_VCS-1:0]               sticky;
        logic [DROP_BITS-1:0]             drop;
    } row_t;

    logic       CLK = 1'b0;
    logic       nRST;
    logic       in_valid;
    flit_t      in_flit;
    logic       out_stall;
    logic       cmd_valid;
    cmd_op_e    cmd_op;
    vc_t        cmd_vc;
    logic       out_valid;
    flit_t      out_flit;
    rx_status_t status;

    row_t        rows[$];
    // per-channel model queues, circular over 16 slots
    flit_t       model_mem [NUM_VCS][16];
    int          head [NUM_VCS];
    int          tail [NUM_VCS];
    logic [31:0] lfsr_state = 32'hcc8c;
    int          cycles = 0;
    int          limit = 0;
    int          last_sample = -100;
    int          first_edge = -100;
    int          last_vc = 0;
    int          sent = 0;
    int          accepted = 0;
    int          cleared = 0;
    int          out_count = 0;
    int          err_data = 0;
    int          err_status = 0;
    int          err_latency = 0;

    chiplet_rx_top UUT (
        .CLK       (CLK),
        .nRST      (nRST),
        .in_valid  (in_valid),
        .in_flit   (in_flit),
        .out_stall (out_stall),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_vc    (cmd_vc),
        .out_valid (out_valid),
        .out_flit  (out_flit),
        .status    (status)
    );

    always #50 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("Test FAILED");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1, one step per payload bit
    function automatic logic [31:0] rand_word();
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int b = 0; b < 32; b++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    // arg is the flit id, the opcode or the wait length
    function automatic row_t mk(row_kind_e kind, int vc, int arg, bit bad);
        row_t r;
        r = '0;
        r.kind = kind;
        r.vc   = vc_t'(vc);
        r.id   = arg[3:0];
        r.op   = cmd_op_e'(arg[1:0]);
        r.n    = arg[7:0];
        r.bad  = bad;
        return r;
    endfunction

    function automatic row_t chk(int c0, int c1, int c2, int c3, int sticky, int drop);
        row_t r;
        r = mk(K_CHECK, 0, 0, 1'b0);
        r.cnt    = {CNT_BITS'(c3), CNT_BITS'(c2), CNT_BITS'(c1), CNT_BITS'(c0)};
        r.sticky = NUM_VCS'(sticky);
        r.drop   = DROP_BITS'(drop);
        return r;
    endfunction

    task automatic burst(input int vc, input int num, input int first_id);
        for (int i = 0; i < num; i++) begin
            rows.push_back(mk(K_SEND, vc, first_id + i, 1'b0));
        end
    endtask

    task automatic check_status(input row_t r);
        for (int i = 0; i < NUM_VCS; i++) begin
            assert (status.count[i] == r.cnt[i]) else begin
                err_status++;
                $display("Error at %0t ns: channel %0d count is %0d, expected %0d",
                         $time, i, status.count[i], r.cnt[i]);
            end
        end
        assert (status.overrun_sticky == r.sticky) else begin
            err_status++;
            $display("Error at %0t ns: overrun_sticky is %b, expected %b",
                     $time, status.overrun_sticky, r.sticky);
        end
        assert (status.drop_count == r.drop) else begin
            err_status++;
            $display("Error at %0t ns: drop_count is %0d, expected %0d",
                     $time, status.drop_count, r.drop);
        end
    endtask

    task automatic drive_row(input row_t r);
        flit_t f;
        int    v;
        v = int'(r.vc);
        case (r.kind)
            K_SEND: begin
                f.vc      = r.vc;
                f.id      = r.id;
                f.payload = rand_word();
                f.par     = (^{f.vc, f.id, f.payload}) ^ r.bad;
                in_valid <= 1'b1;
                in_flit  <= f;
                // model takes the flit only while the channel has room
                if (!r.bad && tail[v] - head[v] < VC_DEPTH) begin
                    model_mem[v][tail[v] % 16] = f;
                    tail[v]++;
                    accepted++;
                end
                // cycles still holds the count before this edge
                if (sent == 0) begin
                    first_edge = cycles + 2;
                end
                last_sample = cycles + 2;
                sent++;
            end
            K_CMD: begin
                cmd_valid <= 1'b1;
                cmd_op    <= r.op;
                cmd_vc    <= r.vc;
                for (int i = 0; i < NUM_VCS; i++) begin
                    if (r.op == CMD_CLEAR_ALL || (r.op == CMD_CLEAR_VC && i == v)) begin
                        cleared += tail[i] - head[i];
                        head[i] = tail[i];
                    end
                end
            end
            K_STALL_ON:  out_stall <= 1'b1;
            K_STALL_OFF: out_stall <= 1'b0;
            K_WAIT:      repeat (r.n) @(posedge CLK);
            default: begin
                @(negedge CLK);
                check_status(r);
            end
        endcase
    endtask

    // each output flit against the head of its modeled channel
    always @(negedge CLK) begin : output_check
        int v;
        int exp_vc;
        if (nRST && out_valid) begin
            v = int'(out_flit.vc);
            if (out_count == 0) begin
                assert (cycles == first_edge + 3) else begin
                    err_latency++;
                    $display("Error at %0t ns: first flit out at edge %0d, expected edge %0d",
                             $time, cycles, first_edge + 3);
                end
            end
            // rotation is only predictable once the ingress pipeline is empty
            if (last_sample + 3 <= cycles) begin
                exp_vc = -1;
                for (int k = 1; k <= NUM_VCS; k++) begin
                    if (exp_vc < 0 && tail[(last_vc + k) % NUM_VCS] != head[(last_vc + k) % NUM_VCS])
                        exp_vc = (last_vc + k) % NUM_VCS;
                end
                assert (v == exp_vc) else begin
                    err_data++;
                    $display("Error at %0t ns: output from channel %0d, expected channel %0d",
                             $time, v, exp_vc);
                end
            end
            assert (tail[v] != head[v]) else begin
                err_data++;
                $display("Error at %0t ns: unexpected flit id %0h on channel %0d",
                         $time, out_flit.id, v);
            end
            if (tail[v] != head[v]) begin
                assert (out_flit == model_mem[v][head[v] % 16]) else begin
                    err_data++;
                    $display("Error at %0t ns: channel %0d gave %h, expected %h",
                             $time, v, out_flit, model_mem[v][head[v] % 16]);
                end
                head[v]++;
            end
            last_vc = v;
            out_count++;
        end
    end

    initial begin
        int total;
        int mix [9];
        nRST      <= 1'b0;
        in_valid  <= 1'b0;
        in_flit   <= '0;
        out_stall <= 1'b0;
        cmd_valid <= 1'b0;
        cmd_op    <= CMD_NOP;
        cmd_vc    <= '0;
        mix = '{0, 1, 3, 0, 2, 3, 0, 1, 3};

        // reset state, then one flit on an idle link
        rows.push_back(chk(0, 0, 0, 0, 0, 0));
        rows.push_back(mk(K_SEND, 1, 1, 1'b0));
        rows.push_back(mk(K_WAIT, 0, 6, 1'b0));
        rows.push_back(chk(0, 0, 0, 0, 0, 0));
        // bad parity on both sides of a good flit
        rows.push_back(mk(K_SEND, 0, 2, 1'b1));
        rows.push_back(mk(K_SEND, 0, 3, 1'b0));
        rows.push_back(mk(K_SEND, 3, 4, 1'b1));
        rows.push_back(mk(K_WAIT, 0, 6, 1'b0));
        rows.push_back(chk(0, 0, 0, 0, 0, 2));
        // ten flits into one stalled channel
        rows.push_back(mk(K_STALL_ON, 0, 0, 1'b0));
        burst(2, 10, 0);
        rows.push_back(mk(K_WAIT, 0, 5, 1'b0));
        rows.push_back(chk(0, 0, 8, 0, 4'b0100, 2));
        rows.push_back(mk(K_STALL_OFF, 0, 0, 1'b0));
        rows.push_back(mk(K_WAIT, 0, 12, 1'b0));
        rows.push_back(chk(0, 0, 0, 0, 4'b0100, 2));
        // all channels loaded, then drained round robin
        rows.push_back(mk(K_STALL_ON, 0, 0, 1'b0));
        for (int i = 0; i < 9; i++) begin
            rows.push_back(mk(K_SEND, mix[i], i + 5, 1'b0));
        end
        rows.push_back(mk(K_WAIT, 0, 5, 1'b0));
        rows.push_back(chk(3, 2, 1, 3, 4'b0100, 2));
        rows.push_back(mk(K_STALL_OFF, 0, 0, 1'b0));
        rows.push_back(mk(K_WAIT, 0, 14, 1'b0));
        rows.push_back(chk(0, 0, 0, 0, 4'b0100, 2));
        // single channel clear, then clear all
        rows.push_back(mk(K_STALL_ON, 0, 0, 1'b0));
        burst(0, 4, 0);
        burst(3, 2, 4);
        rows.push_back(mk(K_WAIT, 0, 5, 1'b0));
        rows.push_back(chk(4, 0, 0, 2, 4'b0100, 2));
        rows.push_back(mk(K_CMD, 0, CMD_CLEAR_VC, 1'b0));
        rows.push_back(mk(K_WAIT, 0, 3, 1'b0));
        rows.push_back(chk(0, 0, 0, 2, 4'b0100, 2));
        burst(1, 3, 6);
        rows.push_back(mk(K_WAIT, 0, 5, 1'b0));
        rows.push_back(chk(0, 3, 0, 2, 4'b0100, 2));
        rows.push_back(mk(K_CMD, 0, CMD_CLEAR_ALL, 1'b0));
        rows.push_back(mk(K_WAIT, 0, 3, 1'b0));
        rows.push_back(chk(0, 0, 0, 0, 4'b0100, 2));
        rows.push_back(mk(K_STALL_OFF, 0, 0, 1'b0));
        rows.push_back(mk(K_WAIT, 0, 6, 1'b0));
        rows.push_back(chk(0, 0, 0, 0, 4'b0100, 2));
        // acknowledge, then a fresh overrun on another channel
        rows.push_back(mk(K_CMD, 0, CMD_ACK_ERR, 1'b0));
        rows.push_back(mk(K_WAIT, 0, 3, 1'b0));
        rows.push_back(chk(0, 0, 0, 0, 0, 2));
        rows.push_back(mk(K_STALL_ON, 0, 0, 1'b0));
        burst(1, 9, 0);
        rows.push_back(mk(K_WAIT, 0, 5, 1'b0));
        rows.push_back(chk(0, 8, 0, 0, 4'b0010, 2));
        rows.push_back(mk(K_STALL_OFF, 0, 0, 1'b0));
        rows.push_back(mk(K_WAIT, 0, 12, 1'b0));
        rows.push_back(chk(0, 0, 0, 0, 4'b0010, 2));

        total = 3;
        foreach (rows[i]) begin
            total += 1 + ((rows[i].kind == K_WAIT) ? int'(rows[i].n) : 0);
        end
        limit = 4 * total + 100;

        repeat (3) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        assert (out_valid == 1'b0) else begin
            err_status++;
            $display("Error at %0t ns: out_valid high after reset", $time);
        end

        foreach (rows[i]) begin
            @(posedge CLK);
            in_valid  <= 1'b0;
            cmd_valid <= 1'b0;
            drive_row(rows[i]);
        end

        for (int i = 0; i < NUM_VCS; i++) begin
            assert (tail[i] == head[i]) else begin
                err_data++;
                $display("Error at %0t ns: channel %0d still holds %0d modeled flits",
                         $time, i, tail[i] - head[i]);
            end
        end
        assert (out_count + cleared == accepted) else begin
            err_data++;
            $display("Error at %0t ns: %0d flits out and %0d cleared, %0d accepted",
                     $time, out_count, cleared, accepted);
        end
        $display("errors: %0d data, %0d status, %0d latency (%0d flits out)",
                 err_data, err_status, err_latency, out_count);
        if (err_data + err_status + err_latency == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
hdl/chiplet_types_pkg.sv
hdl/flit_buffers.sv
hdl/flit_ingress.sv
hdl/vc_arbiter.sv
hdl/buffer_ctrl.sv
hdl/chiplet_rx_top.sv
bench/chiplet_rx_tb.sv
